// File: Makefile
# Verilator lint and simulation of the video transmit unit

VERILATOR = verilator
VFLAGS    = --timing -j 0
TOP       = videoTxTb
FILELIST  = tb.f
OBJDIR    = obj_dir
PASS      = TEST OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o $(TOP)
	@out="$$(./$(OBJDIR)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)

// File: bench/videoTxTb.sv
// Video transmit unit testbench
`timescale 1ns/10ps

module videoTxTb
	import videoPkg::*;
();

	// ------------------------------------------------------------------------
	// Programmed raster and run length
	// ------------------------------------------------------------------------

	localparam int lpHActive       = 40;
	localparam int lpHSyncStart    = 44;
	localparam int lpHSyncEnd      = 48;
	localparam int lpHTotal        = 52;
	localparam int lpVActive       = 6;
	localparam int lpVSyncStart    = 7;
	localparam int lpVSyncEnd      = 8;
	localparam int lpVTotal        = 10;
	localparam int lpFrameCycles   = lpHTotal * lpVTotal;
	localparam int lpResetCycles   = 10;
	// Twelve frames plus room for reset and the disabled phase
	localparam int lpTimeoutCycles = 12 * lpFrameCycles + lpResetCycles + 100;
	localparam int lpFrames        = 8;
	localparam int lpDutyCount     = 6;
	localparam int lpBlPeriod      = 2 ** lpBlWidth;

	// DUT pins
	logic                 iVideoClk;
	logic                 arstN;
	logic                 iVideoEn;
	logic [lpHWidth-1:0]  iHActive, iHSyncStart, iHSyncEnd, iHTotal;
	logic [lpVWidth-1:0]  iVActive, iVSyncStart, iVSyncEnd, iVTotal;
	videoPatternE         iPattern;
	rgbT                  iSolidColor;
	logic [lpBlWidth-1:0] iBlDuty;
	logic [3:0]           oTftColorR, oTftColorG, oTftColorB;
	logic                 oTftDclk, oTftHSync, oTftVSync, oTftDe, oTftBackLight;

	// Stimulus tables filled before the run
	integer               seed;
	logic [31:0]          randWord;
	rgbT                  solidList [lpFrames + 1];
	logic [lpBlWidth-1:0] dutyList [lpDutyCount];

	// Raster rebuilt from the pins
	int           x, y, hsHigh, lastHsRise, lastVsRise, cycleCnt;
	int           pixelChecks, framesDone, dutyChecks;
	logic         prevDe, prevHs, prevVs;
	videoPatternE framePattern;
	rgbT          frameSolid;
	rgbT          pinColor;

	assign pinColor = {oTftColorR, oTftColorG, oTftColorB};

	videoTxUnit i_videoTxUnit (.*);

	always #5 iVideoClk = ~iVideoClk;

	// ------------------------------------------------------------------------
	// Reference model and compares
	// ------------------------------------------------------------------------

	// Pattern colour at active pixel x,y
	function automatic rgbT refColor(videoPatternE pattern, rgbT solid, int px, int py);
		rgbT        res;
		logic [2:0] bar;
		int         sum;
		bar = px[5:3];
		sum = px + py;
		case (pattern)
			patSolid:
				res = solid;
			patColorBars:
			begin
				res.r = bar[2] ? 4'hf : 4'h0;
				res.g = bar[1] ? 4'hf : 4'h0;
				res.b = bar[0] ? 4'hf : 4'h0;
			end
			patGradient:
			begin
				res.r = px[3:0];
				res.g = py[3:0];
				res.b = sum[3:0];
			end
			default:
				res = (px[3] != py[3]) ? 12'hfff : 12'h000;
		endcase
		return res;
	endfunction

	task automatic abortRun(string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic colorMatch(string name, rgbT got, rgbT exp);
		logic [11:0] gotBits;
		logic [11:0] expBits;
		gotBits = got;
		expBits = exp;
		if (gotBits !== expBits)
			abortRun($sformatf("ERR %s got 0x%03h expected 0x%03h", name, gotBits, expBits));
	endtask

	task automatic levelMatch(string name, logic got, logic exp);
		if (got !== exp)
			abortRun($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic countMatch(string name, int got, int exp);
		if (got != exp)
			abortRun($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic dutyMatch(string name, logic [lpBlWidth-1:0] got, logic [lpBlWidth-1:0] exp);
		if (got !== exp)
			abortRun($sformatf("ERR %s got 0x%02h expected 0x%02h", name, got, exp));
	endtask

	// Pins sampled mid-cycle away from the driving edge
	always @(negedge iVideoClk)
	begin
		if (arstN && !iVideoEn)
		begin
			levelMatch("oTftHSync", oTftHSync, 1'b0);
			levelMatch("oTftVSync", oTftVSync, 1'b0);
			levelMatch("oTftDe", oTftDe, 1'b0);
			levelMatch("oTftBackLight", oTftBackLight, 1'b0);
		end
		if (oTftDe)
		begin
			// First pixel of a frame fixes its pattern
			if (x == 0 && y == 0)
			begin
				framePattern = iPattern;
				frameSolid   = iSolidColor;
			end
			colorMatch("oTftColor", pinColor, refColor(framePattern, frameSolid, x, y));
			pixelChecks++;
			x++;
		end
		else
			colorMatch("oTftColor", pinColor, '0);
		// End of an active line
		if (prevDe && !oTftDe)
		begin
			countMatch("oTftDe cycles per line", x, lpHActive);
			x = 0;
			y++;
		end
		// Horizontal sync period and width
		if (oTftHSync && !prevHs)
		begin
			if (lastHsRise >= 0)
				countMatch("oTftHSync period", cycleCnt - lastHsRise, lpHTotal);
			lastHsRise = cycleCnt;
			hsHigh     = 0;
		end
		if (oTftHSync)
			hsHigh++;
		if (!oTftHSync && prevHs)
			countMatch("oTftHSync width", hsHigh, lpHSyncEnd - lpHSyncStart);
		// Vertical sync closes a frame
		if (oTftVSync && !prevVs)
		begin
			countMatch("oTftDe lines per frame", y, lpVActive);
			if (lastVsRise >= 0)
				countMatch("oTftVSync period", cycleCnt - lastVsRise, lpFrameCycles);
			lastVsRise = cycleCnt;
			y          = 0;
			framesDone++;
		end
		prevDe = oTftDe;
		prevHs = oTftHSync;
		prevVs = oTftVSync;
	end

	// Pixel clock pin follows the clock in both phases
	always @(iVideoClk)
	begin
		#1;
		levelMatch("oTftDclk", oTftDclk, iVideoClk);
	end

	always @(posedge iVideoClk)
	begin
		cycleCnt++;
		if (cycleCnt > lpTimeoutCycles)
			abortRun($sformatf("Run did not finish within %0d cycles", lpTimeoutCycles));
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	// Two frames per pattern with every change landing mid-frame
	task automatic drivePatterns();
		for (int f = 0; f < lpFrames; f++)
		begin
			if (f == 0)
				repeat (150) @(posedge iVideoClk);
			else
			begin
				@(posedge oTftVSync);
				// Line 2 of the next frame
				repeat (270) @(posedge iVideoClk);
			end
			#1;
			iSolidColor = solidList[f + 1];
			case (f)
				1: iPattern = patColorBars;
				3: iPattern = patGradient;
				5: iPattern = patChecker;
				7: iPattern = patSolid;
				default: ;
			endcase
		end
		@(posedge oTftVSync);
	endtask

	task automatic sweepBacklight();
		logic prevBl;
		logic riseSeen;
		int   highs;
		for (int i = 0; i < lpDutyCount; i++)
		begin
			@(posedge iVideoClk);
			#1 iBlDuty = dutyList[i];
			// Periods begun on the old duty are over
			repeat (lpBlPeriod + 1) @(negedge iVideoClk);
			if (dutyList[i] == '0)
			begin
				repeat (2 * lpBlPeriod)
				begin
					@(negedge iVideoClk);
					levelMatch("oTftBackLight", oTftBackLight, 1'b0);
				end
			end
			else
			begin
				prevBl   = oTftBackLight;
				riseSeen = 1'b0;
				while (!riseSeen)
				begin
					@(negedge iVideoClk);
					riseSeen = !prevBl && oTftBackLight;
					prevBl   = oTftBackLight;
				end
				// One period counted from the rise
				highs = 1;
				repeat (lpBlPeriod - 1)
				begin
					@(negedge iVideoClk);
					if (oTftBackLight)
						highs++;
				end
				dutyMatch("oTftBackLight high cycles", highs[lpBlWidth-1:0], dutyList[i]);
			end
			dutyChecks++;
		end
	endtask

	initial
	begin
		seed         = 32'h987b;
		iVideoClk    = 1'b0;
		arstN        = 1'b0;
		iVideoEn     = 1'b0;
		iHActive     = lpHWidth'(lpHActive);
		iHSyncStart  = lpHWidth'(lpHSyncStart);
		iHSyncEnd    = lpHWidth'(lpHSyncEnd);
		iHTotal      = lpHWidth'(lpHTotal);
		iVActive     = lpVWidth'(lpVActive);
		iVSyncStart  = lpVWidth'(lpVSyncStart);
		iVSyncEnd    = lpVWidth'(lpVSyncEnd);
		iVTotal      = lpVWidth'(lpVTotal);
		iPattern     = patSolid;
		iSolidColor  = '0;
		iBlDuty      = '0;
		x            = 0;
		y            = 0;
		hsHigh       = 0;
		lastHsRise   = -1;
		lastVsRise   = -1;
		cycleCnt     = 0;
		pixelChecks  = 0;
		framesDone   = 0;
		dutyChecks   = 0;
		prevDe       = 1'b0;
		prevHs       = 1'b0;
		prevVs       = 1'b0;
		framePattern = patSolid;
		frameSolid   = '0;
		// All random data drawn up front in a fixed order
		for (int i = 0; i <= lpFrames; i++)
		begin
			randWord     = $random(seed);
			solidList[i] = randWord[11:0];
		end
		for (int i = 0; i < lpDutyCount; i++)
		begin
			randWord    = $random(seed);
			dutyList[i] = randWord[lpBlWidth-1:0];
		end
		// Edge cases in between
		dutyList[1] = '0;
		dutyList[3] = '1;
		repeat (lpResetCycles) @(posedge iVideoClk);
		#1 arstN = 1'b1;
		// Disabled raster keeps the pins quiet
		repeat (20) @(posedge iVideoClk);
		#1;
		iSolidColor = solidList[0];
		iVideoEn    = 1'b1;
		fork
			drivePatterns();
			sweepBacklight();
		join
		if (pixelChecks < lpFrames * lpHActive * lpVActive || framesDone < lpFrames ||
			dutyChecks != lpDutyCount)
			abortRun($sformatf("Too few checks ran: %0d pixels, %0d frames, %0d duty values",
				pixelChecks, framesDone, dutyChecks));
		else
		begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// File: rtl/backlightPwm.sv
// Backlight dimming PWM
`timescale 1ns/10ps

module backlightPwm
	import videoPkg::*;
(
	input  logic                 iVideoClk,
	input  logic                 arstN,
	input  logic [lpBlWidth-1:0] iDuty,
	output logic                 pwm
);

	// ------------------------------------------------------------------------
	// Period counter and duty
	// ------------------------------------------------------------------------

	logic [lpBlWidth-1:0] periodCnt;
	logic [lpBlWidth-1:0] dutyReg;
	logic [lpBlWidth-1:0] dutyNow;

	// New duty takes effect right at period start
	assign dutyNow = (periodCnt == '0) ? iDuty : dutyReg;

	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
		begin
			periodCnt <= '0;
			dutyReg   <= '0;
		end
		else
		begin
			// Wraps after 255
			periodCnt <= periodCnt + 1'b1;
			if (periodCnt == '0)
				dutyReg <= iDuty;
		end
	end

	// ------------------------------------------------------------------------
	// Output compare
	// ------------------------------------------------------------------------

	// Zero duty never goes high
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
			pwm <= 1'b0;
		else
			pwm <= (periodCnt < dutyNow);
	end

endmodule

// File: rtl/videoOutStage.sv
// Panel output stage
`timescale 1ns/10ps

module videoOutStage
	import videoPkg::*;
(
	input  logic        iVideoClk,
	input  logic        arstN,
	videoRasterIf.timing raster,
	input  rgbT         pixel,
	output logic        hSync,
	output logic        vSync,
	output logic        de,
	output rgbT         color
);

	// ------------------------------------------------------------------------
	// Sync delay line
	// ------------------------------------------------------------------------

	// Bit 2 hSync, bit 1 vSync, bit 0 de
	logic [2:0]                          syncIn;
	logic [lpPixelLatency-1:0][2:0]      syncDly;
	logic [2:0]                          syncAligned;

	assign syncIn      = {raster.hSync, raster.vSync, raster.de};
	assign syncAligned = syncDly[lpPixelLatency-1];

	// Matches the pixel pipeline depth
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
			syncDly <= '0;
		else
			syncDly <= {syncDly[lpPixelLatency-2:0], syncIn};
	end

	// ------------------------------------------------------------------------
	// Pin registers
	// ------------------------------------------------------------------------

	// All pins leave from flops
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
		begin
			hSync <= 1'b0;
			vSync <= 1'b0;
			de    <= 1'b0;
			color <= '0;
		end
		else
		begin
			hSync <= syncAligned[2];
			vSync <= syncAligned[1];
			de    <= syncAligned[0];
			// Colour forced dark in blanking
			if (syncAligned[0])
				color <= pixel;
			else
				color <= '0;
		end
	end

endmodule

// File: rtl/videoPixelGen.sv
// Test pattern pixel pipeline
`timescale 1ns/10ps

module videoPixelGen
	import videoPkg::*;
(
	input  logic         iVideoClk,
	input  logic         arstN,
	videoRasterIf.pixel  raster,
	input  videoPatternE iPattern,
	input  rgbT          iSolidColor,
	output rgbT          pixel
);

	// ------------------------------------------------------------------------
	// Stage one
	// ------------------------------------------------------------------------

	// Pattern held for the whole frame
	videoPatternE patternReg;
	rgbT          solidReg;

	// Only the low position bits feed any pattern
	logic [5:0] hPos;
	logic [3:0] vPos;
	logic       dePos;

	// Control, latched on frame start only
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
		begin
			patternReg <= patSolid;
			dePos      <= 1'b0;
		end
		else
		begin
			dePos <= raster.de;
			if (raster.frameStart)
				patternReg <= iPattern;
		end
	end

	// Payload, no reset
	always_ff @(posedge iVideoClk)
	begin
		hPos <= raster.hCount[5:0];
		vPos <= raster.vCount[3:0];
		if (raster.frameStart)
			solidReg <= iSolidColor;
	end

	// ------------------------------------------------------------------------
	// Stage two
	// ------------------------------------------------------------------------

	rgbT        colorNext;
	logic [2:0] barIdx;
	logic [3:0] gradSum;
	logic       checkerOn;

	always_comb
	begin
		// Eight bars, eight pixels wide
		barIdx    = hPos[5:3];
		gradSum   = hPos[3:0] + vPos[3:0];
		checkerOn = hPos[3] ^ vPos[3];
		case (patternReg)
			patSolid:
				colorNext = solidReg;
			patColorBars:
			begin
				colorNext.r = {4{barIdx[2]}};
				colorNext.g = {4{barIdx[1]}};
				colorNext.b = {4{barIdx[0]}};
			end
			patGradient:
			begin
				colorNext.r = hPos[3:0];
				colorNext.g = vPos;
				colorNext.b = gradSum;
			end
			default:
				// 8x8 checker board
				colorNext = checkerOn ? 12'hfff : 12'h000;
		endcase
	end

	// Blank outside active area already here
	always_ff @(posedge iVideoClk)
	begin
		pixel <= dePos ? colorNext : '0;
	end

endmodule

// File: rtl/videoPkg.sv
// Video transmit shared definitions
package videoPkg;

	// ------------------------------------------------------------------------
	// Raster geometry
	// ------------------------------------------------------------------------

	// Horizontal count and timing width
	localparam int lpHWidth = 11;

	// Vertical count and timing width
	localparam int lpVWidth = 11;

	// ------------------------------------------------------------------------
	// Pipeline and backlight
	// ------------------------------------------------------------------------

	// Cycles from raster position to pixel colour
	localparam int lpPixelLatency = 2;

	// Backlight duty and period counter width
	localparam int lpBlWidth = 8;

	// ------------------------------------------------------------------------
	// Types
	// ------------------------------------------------------------------------

	// Test pattern select
	typedef enum logic [1:0]
	{
		patSolid     = 2'd0,
		patColorBars = 2'd1,
		patGradient  = 2'd2,
		patChecker   = 2'd3
	} videoPatternE;

	// RGB444 pixel, red in the top nibble
	typedef struct packed
	{
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgbT;

endpackage

// File: rtl/videoRasterIf.sv
// Raster position and timing bus
`timescale 1ns/10ps

interface videoRasterIf
	import videoPkg::*;
();

	// Current raster position
	logic [lpHWidth-1:0] hCount;
	logic [lpVWidth-1:0] vCount;

	// Timing levels, all active high
	logic hSync;
	logic vSync;
	logic de;

	// Single cycle pulse at position 0,0
	logic frameStart;

	// Sync generator side
	modport source (output hCount, vCount, hSync, vSync, de, frameStart);

	// Pattern pipeline needs the position and frame boundary
	modport pixel (input hCount, vCount, de, frameStart);

	// Output stage only sees the levels
	modport timing (input hSync, vSync, de);

endinterface

// File: rtl/videoSyncGen.sv
// Raster sync generator
`timescale 1ns/10ps

module videoSyncGen
	import videoPkg::*;
(
	input  logic                iVideoClk,
	input  logic                arstN,
	input  logic                iVideoEn,
	input  logic [lpHWidth-1:0] iHActive,
	input  logic [lpHWidth-1:0] iHSyncStart,
	input  logic [lpHWidth-1:0] iHSyncEnd,
	input  logic [lpHWidth-1:0] iHTotal,
	input  logic [lpVWidth-1:0] iVActive,
	input  logic [lpVWidth-1:0] iVSyncStart,
	input  logic [lpVWidth-1:0] iVSyncEnd,
	input  logic [lpVWidth-1:0] iVTotal,
	videoRasterIf.source        raster
);

	// ------------------------------------------------------------------------
	// Next raster position
	// ------------------------------------------------------------------------

	// Set one cycle after enable, so the first enabled cycle shows 0,0
	logic videoRun;

	logic [lpHWidth-1:0] nextH;
	logic [lpVWidth-1:0] nextV;
	logic                hWrap;

	always_comb
	begin
		hWrap = (raster.hCount == iHTotal - 1'b1);
		nextH = raster.hCount;
		nextV = raster.vCount;
		if (!videoRun)
		begin
			// Restart from the origin
			nextH = '0;
			nextV = '0;
		end
		else if (hWrap)
		begin
			nextH = '0;
			// Line done, step the frame counter
			if (raster.vCount == iVTotal - 1'b1)
				nextV = '0;
			else
				nextV = raster.vCount + 1'b1;
		end
		else
		begin
			nextH = raster.hCount + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// Registered position and timing levels
	// ------------------------------------------------------------------------

	// Levels are compared on the next position so they line up with counts
	always_ff @(posedge iVideoClk or negedge arstN)
	begin
		if (!arstN)
		begin
			videoRun          <= 1'b0;
			raster.hCount     <= '0;
			raster.vCount     <= '0;
			raster.hSync      <= 1'b0;
			raster.vSync      <= 1'b0;
			raster.de         <= 1'b0;
			raster.frameStart <= 1'b0;
		end
		else if (!iVideoEn)
		begin
			// Parked at origin, everything inactive
			videoRun          <= 1'b0;
			raster.hCount     <= '0;
			raster.vCount     <= '0;
			raster.hSync      <= 1'b0;
			raster.vSync      <= 1'b0;
			raster.de         <= 1'b0;
			raster.frameStart <= 1'b0;
		end
		else
		begin
			videoRun          <= 1'b1;
			raster.hCount     <= nextH;
			raster.vCount     <= nextV;
			raster.hSync      <= (nextH >= iHSyncStart) && (nextH < iHSyncEnd);
			raster.vSync      <= (nextV >= iVSyncStart) && (nextV < iVSyncEnd);
			raster.de         <= (nextH < iHActive) && (nextV < iVActive);
			raster.frameStart <= (nextH == '0) && (nextV == '0);
		end
	end

endmodule

// File: rtl/videoTxUnit.sv
// TFT video transmit unit
`timescale 1ns/10ps

module videoTxUnit
	import videoPkg::*;
(
	input  logic                 iVideoClk,
	input  logic                 arstN,
	// Raster timing
	input  logic                 iVideoEn,
	input  logic [lpHWidth-1:0]  iHActive,
	input  logic [lpHWidth-1:0]  iHSyncStart,
	input  logic [lpHWidth-1:0]  iHSyncEnd,
	input  logic [lpHWidth-1:0]  iHTotal,
	input  logic [lpVWidth-1:0]  iVActive,
	input  logic [lpVWidth-1:0]  iVSyncStart,
	input  logic [lpVWidth-1:0]  iVSyncEnd,
	input  logic [lpVWidth-1:0]  iVTotal,
	// Content and dimming
	input  videoPatternE         iPattern,
	input  rgbT                  iSolidColor,
	input  logic [lpBlWidth-1:0] iBlDuty,
	// Panel pins
	output logic [3:0]           oTftColorR,
	output logic [3:0]           oTftColorG,
	output logic [3:0]           oTftColorB,
	output logic                 oTftDclk,
	output logic                 oTftHSync,
	output logic                 oTftVSync,
	output logic                 oTftDe,
	output logic                 oTftBackLight
);

	// ------------------------------------------------------------------------
	// Raster, pattern and output path
	// ------------------------------------------------------------------------

	videoRasterIf raster ();

	rgbT pixelColor;
	rgbT pinColor;

	videoSyncGen i_videoSyncGen (
		.iVideoClk   (iVideoClk),
		.arstN       (arstN),
		.iVideoEn    (iVideoEn),
		.iHActive    (iHActive),
		.iHSyncStart (iHSyncStart),
		.iHSyncEnd   (iHSyncEnd),
		.iHTotal     (iHTotal),
		.iVActive    (iVActive),
		.iVSyncStart (iVSyncStart),
		.iVSyncEnd   (iVSyncEnd),
		.iVTotal     (iVTotal),
		.raster      (raster.source)
	);

	// Runs beside the sync generator on the same position
	videoPixelGen i_videoPixelGen (
		.iVideoClk   (iVideoClk),
		.arstN       (arstN),
		.raster      (raster.pixel),
		.iPattern    (iPattern),
		.iSolidColor (iSolidColor),
		.pixel       (pixelColor)
	);

	videoOutStage i_videoOutStage (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.raster    (raster.timing),
		.pixel     (pixelColor),
		.hSync     (oTftHSync),
		.vSync     (oTftVSync),
		.de        (oTftDe),
		.color     (pinColor)
	);

	// ------------------------------------------------------------------------
	// Backlight
	// ------------------------------------------------------------------------

	backlightPwm i_backlightPwm (
		.iVideoClk (iVideoClk),
		.arstN     (arstN),
		.iDuty     (iBlDuty),
		.pwm       (oTftBackLight)
	);

	// Split colour onto pins, pixel clock straight through
	assign oTftColorR = pinColor.r;
	assign oTftColorG = pinColor.g;
	assign oTftColorB = pinColor.b;
	assign oTftDclk   = iVideoClk;

endmodule

// File: tb.f
rtl/videoPkg.sv
rtl/videoRasterIf.sv
rtl/videoSyncGen.sv
rtl/videoPixelGen.sv
rtl/videoOutStage.sv
rtl/backlightPwm.sv
rtl/videoTxUnit.sv
bench/videoTxTb.sv
